// ==== sim.f ====
verilog/lockstep_pkg.sv
verilog/secded_inv_dec.sv
verilog/shadow_reset_ctrl.sv
verilog/shadow_input_delay.sv
verilog/acc_core.sv
verilog/bus_intg_check.sv
verilog/lockstep_compare.sv
verilog/lockstep_top.sv
bench/lockstep_tb.sv

// ==== Bender.yml ====
package:
  name: lockstep_checker

sources:
  - verilog/lockstep_pkg.sv
  - verilog/secded_inv_dec.sv
  - verilog/shadow_reset_ctrl.sv
  - verilog/shadow_input_delay.sv
  - verilog/acc_core.sv
  - verilog/bus_intg_check.sv
  - verilog/lockstep_compare.sv
  - verilog/lockstep_top.sv
  - target: simulation
    files:
      - bench/lockstep_tb.sv

// ==== bench/lockstep_tb.sv ====
// Lockstep checker testbench
module lockstep_tb import lockstep_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LockstepOffset = 2;
  localparam int ResetCycles = 5;
  localparam int MinCleanReads = 100;
  localparam int ExpDepth = 1024;
  localparam int NumEvents = 8;

  // Fault kinds
  localparam int KindAccFlip = 0;
  localparam int KindIntg1 = 1;
  localparam int KindIntg2 = 2;
  localparam int KindIntgIdle = 3;
  localparam int KindErr = 4;

  // Alert selectors
  localparam int AlertNone = 0;
  localparam int AlertMinor = 1;
  localparam int AlertInternal = 2;
  localparam int AlertBus = 3;

  ////////////////////////////////////////////////////////////
  // Event table
  ////////////////////////////////////////////////////////////

  // Read-related faults wait for the next cycle that fits their kind
  int ev_cycle [NumEvents] = '{320, 340, 360, 380, 400, 420, 440, 460};
  int ev_kind [NumEvents] = '{KindAccFlip, KindIntg1, KindIntg2, KindIntgIdle,
                              KindErr, KindAccFlip, KindErr, KindIntg1};
  int ev_alert [NumEvents] = '{AlertInternal, AlertBus, AlertBus, AlertNone,
                               AlertMinor, AlertInternal, AlertMinor, AlertBus};
  int ev_offset [NumEvents] = '{LockstepOffset + 1, 1, 1, 0,
                                LockstepOffset, LockstepOffset + 1, LockstepOffset, 1};

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             fetch_enable_i;
  logic             data_gnt_i;
  logic             data_rvalid_i;
  logic             data_err_i;
  logic [DataW-1:0] data_rdata_i;
  logic [IntgW-1:0] data_rdata_intg_i;
  logic             data_req_i;
  logic [DataW-1:0] data_addr_i;
  logic [DataW-1:0] acc_i;
  logic             core_busy_i;
  logic             alert_minor_o;
  logic             alert_major_internal_o;
  logic             alert_major_bus_o;

  // Main core model state
  logic             model_outstanding;
  logic [DataW-1:0] model_addr;
  logic [DataW-1:0] model_acc;

  bit     exp_minor [ExpDepth];
  bit     exp_internal [ExpDepth];
  bit     exp_bus [ExpDepth];
  integer seed = 68;
  int     mismatch_cnt = 0;
  int     other_cnt = 0;
  int     reads_clean = 0;
  int     ev = 0;
  int     run_cycles;
  int     flip_bit;
  logic   gnt_next;
  logic   rvalid_next;
  bit     applied;

  always #20 clk_i = ~clk_i;

  lockstep_top #(.LockstepOffset(LockstepOffset)) UUT (
    .clk_i, .rst_ni, .fetch_enable_i, .data_gnt_i, .data_rvalid_i, .data_err_i,
    .data_rdata_i, .data_rdata_intg_i, .data_req_i, .data_addr_i, .acc_i, .core_busy_i,
    .alert_minor_o, .alert_major_internal_o, .alert_major_bus_o
  );

  ////////////////////////////////////////////////////////////
  // Main core model
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      model_outstanding <= 1'b0;
      model_addr        <= CoreBootAddr;
      model_acc         <= '0;
    end else begin
      if (data_req_i && data_gnt_i) begin
        model_outstanding <= 1'b1;
        model_addr        <= model_addr + CoreAddrStep;
      end
      if (data_rvalid_i) begin
        model_outstanding <= 1'b0;
        if (!data_err_i) begin
          model_acc <= model_acc + data_rdata_i;
        end
      end
    end
  end

  // Check bits that give a zero syndrome in the inverted code
  function automatic logic [IntgW-1:0] encode_intg(input logic [DataW-1:0] data);
    logic [IntgW-1:0] intg;
    for (int i = 0; i < IntgW; i++) begin
      intg[i] = (^(data & SecdedParityMasks[i][DataW-1:0])) ^ SecdedInvMask[i];
    end
    return intg;
  endfunction

  task automatic check_alert(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic inject_fault(input int kind, input logic rvalid, output bit done);
    done = 1'b0;
    case (kind)
      KindAccFlip: begin
        flip_bit = {$random(seed)} % DataW;
        acc_i[flip_bit] = ~acc_i[flip_bit];
        done = 1'b1;
      end
      KindIntg1: if (rvalid) begin
        data_rdata_intg_i[0] = ~data_rdata_intg_i[0];
        done = 1'b1;
      end
      KindIntg2: if (rvalid) begin
        data_rdata_intg_i[1] = ~data_rdata_intg_i[1];
        data_rdata_intg_i[4] = ~data_rdata_intg_i[4];
        done = 1'b1;
      end
      KindIntgIdle: if (!rvalid) begin
        data_rdata_intg_i[2] = ~data_rdata_intg_i[2];
        done = 1'b1;
      end
      KindErr: if (rvalid) begin
        data_err_i = 1'b1;
        done = 1'b1;
      end
      default: done = 1'b0;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni            = 1'b0;
    fetch_enable_i    = 1'b0;
    data_gnt_i        = 1'b0;
    data_rvalid_i     = 1'b0;
    data_err_i        = 1'b0;
    data_rdata_i      = '0;
    data_rdata_intg_i = '0;
    data_req_i        = 1'b0;
    data_addr_i       = '0;
    acc_i             = '0;
    core_busy_i       = 1'b0;
    run_cycles        = ev_cycle[NumEvents-1] + 20;

    for (int k = 0; k < run_cycles; k++) begin
      @(negedge clk_i);
      check_alert("alert_minor_o", alert_minor_o, exp_minor[k]);
      check_alert("alert_major_internal_o", alert_major_internal_o, exp_internal[k]);
      check_alert("alert_major_bus_o", alert_major_bus_o, exp_bus[k]);

      // Memory grants a pending request and answers one cycle later
      gnt_next    = data_req_i & ~data_gnt_i;
      rvalid_next = data_gnt_i;

      rst_ni            = (k >= ResetCycles);
      fetch_enable_i    = rst_ni;
      data_gnt_i        = gnt_next;
      data_rvalid_i     = rvalid_next;
      data_err_i        = 1'b0;
      data_rdata_i      = rvalid_next ? $random(seed) : '0;
      data_rdata_intg_i = encode_intg(data_rdata_i);
      data_req_i        = fetch_enable_i & ~model_outstanding;
      data_addr_i       = model_addr;
      acc_i             = model_acc;
      core_busy_i       = model_outstanding;

      if (rvalid_next && ev == 0) begin
        reads_clean++;
      end

      if (ev < NumEvents && k >= ev_cycle[ev]) begin
        inject_fault(ev_kind[ev], rvalid_next, applied);
        if (applied) begin
          case (ev_alert[ev])
            AlertMinor:    exp_minor[k + ev_offset[ev]] = 1'b1;
            AlertInternal: exp_internal[k + ev_offset[ev]] = 1'b1;
            AlertBus:      exp_bus[k + ev_offset[ev]] = 1'b1;
            default:       ;
          endcase
          ev++;
        end
      end
    end

    if (ev < NumEvents) begin
      $display("Timeout: fault event %0d was not injected before cycle %0d", ev, run_cycles);
      other_cnt++;
    end
    if (reads_clean < MinCleanReads) begin
      $display("Only %0d fault-free reads ran before the first fault", reads_clean);
      other_cnt++;
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/lockstep_top.sv ====
// Dual-core lockstep checker
module lockstep_top import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  input  logic             data_err_i,
  input  logic [DataW-1:0] data_rdata_i,
  input  logic [IntgW-1:0] data_rdata_intg_i,
  input  logic             data_req_i,
  input  logic [DataW-1:0] data_addr_i,
  input  logic [DataW-1:0] acc_i,
  input  logic             core_busy_i,
  output logic             alert_minor_o,
  output logic             alert_major_internal_o,
  output logic             alert_major_bus_o
);

  logic             shadow_rst_n;
  logic             cmp_en;
  logic             fetch_enable_dly;
  logic             data_gnt_dly;
  logic             data_rvalid_dly;
  logic             data_err_dly;
  logic [DataW-1:0] data_rdata_dly;
  logic             rvalid_q1;
  logic [DataW-1:0] rdata_q1;
  logic             shadow_req;
  logic [DataW-1:0] shadow_addr;
  logic [DataW-1:0] shadow_acc;
  logic             shadow_busy;

  ////////////////////////////////////////////////////////////
  // Reset sequencing and input delay
  ////////////////////////////////////////////////////////////

  shadow_reset_ctrl #(.LockstepOffset(LockstepOffset)) u_reset_ctrl (
    .clk_i, .rst_ni, .shadow_rst_no(shadow_rst_n), .cmp_en_o(cmp_en)
  );

  shadow_input_delay #(.LockstepOffset(LockstepOffset)) u_input_delay (
    .clk_i, .rst_ni, .fetch_enable_i, .data_gnt_i, .data_rvalid_i, .data_err_i, .data_rdata_i,
    .fetch_enable_dly_o(fetch_enable_dly), .data_gnt_dly_o(data_gnt_dly),
    .data_rvalid_dly_o(data_rvalid_dly), .data_err_dly_o(data_err_dly),
    .data_rdata_dly_o(data_rdata_dly), .rvalid_q1_o(rvalid_q1), .rdata_q1_o(rdata_q1)
  );

  ////////////////////////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////////////////////////

  acc_core u_shadow_core (
    .clk_i, .rst_ni(shadow_rst_n), .fetch_enable_i(fetch_enable_dly),
    .data_gnt_i(data_gnt_dly), .data_rvalid_i(data_rvalid_dly), .data_err_i(data_err_dly),
    .data_rdata_i(data_rdata_dly), .data_req_o(shadow_req), .data_addr_o(shadow_addr),
    .acc_o(shadow_acc), .core_busy_o(shadow_busy), .alert_minor_o
  );

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  bus_intg_check u_intg_check (
    .clk_i, .rst_ni, .data_rdata_intg_i, .rvalid_q1_i(rvalid_q1), .rdata_q1_i(rdata_q1),
    .alert_major_bus_o
  );

  lockstep_compare #(.LockstepOffset(LockstepOffset)) u_compare (
    .clk_i, .rst_ni, .cmp_en_i(cmp_en),
    .main_req_i(data_req_i), .main_addr_i(data_addr_i), .main_acc_i(acc_i),
    .main_busy_i(core_busy_i), .shadow_req_i(shadow_req), .shadow_addr_i(shadow_addr),
    .shadow_acc_i(shadow_acc), .shadow_busy_i(shadow_busy), .alert_major_internal_o
  );

endmodule

// ==== verilog/lockstep_compare.sv ====
// Lockstep output comparator
module lockstep_compare import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             cmp_en_i,
  input  logic             main_req_i,
  input  logic [DataW-1:0] main_addr_i,
  input  logic [DataW-1:0] main_acc_i,
  input  logic             main_busy_i,
  input  logic             shadow_req_i,
  input  logic [DataW-1:0] shadow_addr_i,
  input  logic [DataW-1:0] shadow_acc_i,
  input  logic             shadow_busy_i,
  output logic             alert_major_internal_o
);

  // Main outputs wait one extra cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;
  localparam int unsigned BundleW       = 2 * DataW + 2;

  logic [BundleW-1:0] main_d;
  logic [BundleW-1:0] main_q [OutputsOffset];
  logic [BundleW-1:0] shadow_q;

  assign main_d = {main_req_i, main_addr_i, main_acc_i, main_busy_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < OutputsOffset; i++) begin
        main_q[i] <= '0;
      end
      shadow_q <= '0;
    end else begin
      for (int unsigned i = 0; i < OutputsOffset - 1; i++) begin
        main_q[i] <= main_q[i+1];
      end
      main_q[OutputsOffset-1] <= main_d;
      shadow_q <= {shadow_req_i, shadow_addr_i, shadow_acc_i, shadow_busy_i};
    end
  end

  // Oldest main stage lines up with the registered shadow outputs
  assign alert_major_internal_o = cmp_en_i & (shadow_q != main_q[0]);

endmodule

// ==== verilog/bus_intg_check.sv ====
// Read data integrity check
module bus_intg_check import lockstep_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [IntgW-1:0] data_rdata_intg_i,
  input  logic             rvalid_q1_i,
  input  logic [DataW-1:0] rdata_q1_i,
  output logic             alert_major_bus_o
);

  logic [IntgW-1:0] intg_q;
  logic [1:0]       intg_err;

  // Align the check bits with the delayed read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intg_q <= '0;
    end else begin
      intg_q <= data_rdata_intg_i;
    end
  end

  secded_inv_dec u_rdata_dec (
    .data_i     ({intg_q, rdata_q1_i}),
    .syndrome_o (),
    .err_o      (intg_err)
  );

  // Only a valid read is checked
  assign alert_major_bus_o = rvalid_q1_i & (|intg_err);

endmodule

// ==== verilog/acc_core.sv ====
// Load-accumulate core
module acc_core import lockstep_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  input  logic             data_err_i,
  input  logic [DataW-1:0] data_rdata_i,
  output logic             data_req_o,
  output logic [DataW-1:0] data_addr_o,
  output logic [DataW-1:0] acc_o,
  output logic             core_busy_o,
  output logic             alert_minor_o
);

  logic             outstanding_q;
  logic [DataW-1:0] addr_q;
  logic [DataW-1:0] acc_q;
  logic             req_accepted;

  // One load in flight at most
  assign data_req_o   = fetch_enable_i & ~outstanding_q;
  assign req_accepted = data_req_o & data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      addr_q        <= CoreBootAddr;
      acc_q         <= '0;
    end else begin
      if (req_accepted) begin
        outstanding_q <= 1'b1;
        addr_q        <= addr_q + CoreAddrStep;
      end
      if (data_rvalid_i) begin
        outstanding_q <= 1'b0;
        // Erroneous reads are dropped
        if (!data_err_i) begin
          acc_q <= acc_q + data_rdata_i;
        end
      end
    end
  end

  assign data_addr_o   = addr_q;
  assign acc_o         = acc_q;
  assign core_busy_o   = outstanding_q;
  assign alert_minor_o = data_rvalid_i & data_err_i;

  ////////////////////////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////////////////////////

  rvalid_needs_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> outstanding_q);

endmodule

// ==== verilog/shadow_input_delay.sv ====
// Shadow core input delay line
module shadow_input_delay import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  input  logic             data_err_i,
  input  logic [DataW-1:0] data_rdata_i,
  output logic             fetch_enable_dly_o,
  output logic             data_gnt_dly_o,
  output logic             data_rvalid_dly_o,
  output logic             data_err_dly_o,
  output logic [DataW-1:0] data_rdata_dly_o,
  output logic             rvalid_q1_o,
  output logic [DataW-1:0] rdata_q1_o
);

  localparam int unsigned StageW = DataW + 4;

  logic [StageW-1:0] stage_d;
  // Index 0 is the oldest stage
  logic [StageW-1:0] stage_q [LockstepOffset];

  assign stage_d = {fetch_enable_i, data_gnt_i, data_rvalid_i, data_err_i, data_rdata_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < LockstepOffset; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < LockstepOffset - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[LockstepOffset-1] <= stage_d;
    end
  end

  assign {fetch_enable_dly_o, data_gnt_dly_o, data_rvalid_dly_o, data_err_dly_o,
          data_rdata_dly_o} = stage_q[0];

  // One-cycle copy for the integrity check
  assign rvalid_q1_o = stage_q[LockstepOffset-1][DataW+1];
  assign rdata_q1_o  = stage_q[LockstepOffset-1][DataW-1:0];

endmodule

// ==== verilog/shadow_reset_ctrl.sv ====
// Shadow core reset sequencer
module shadow_reset_ctrl #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            rst_set_d;

  // Counter saturates once the shadow core may leave reset
  assign rst_set_d = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d     = rst_set_d ? cnt_q : cnt_q + CntW'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q         <= '0;
      shadow_rst_no <= 1'b0;
      cmp_en_o      <= 1'b0;
    end else begin
      cnt_q         <= cnt_d;
      shadow_rst_no <= rst_set_d;
      // Comparison starts one cycle after the shadow core is released
      cmp_en_o      <= shadow_rst_no;
    end
  end

  if (LockstepOffset < 2) begin : gen_offset_check
    $error("LockstepOffset must be at least 2");
  end

  cmp_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmp_en_o) |-> shadow_rst_no);

endmodule

// ==== verilog/secded_inv_dec.sv ====
// Inverted SECDED syndrome decoder
module secded_inv_dec import lockstep_pkg::*; (
  input  logic [CodeW-1:0] data_i,
  output logic [IntgW-1:0] syndrome_o,
  output logic [1:0]       err_o
);

  logic syndrome_odd;
  logic syndrome_nz;

  ////////////////////////////////////////////////////////////
  // Syndrome
  ////////////////////////////////////////////////////////////

  // Parity over each masked codeword, then undo the stored inversion
  always_comb begin
    for (int unsigned i = 0; i < IntgW; i++) begin
      syndrome_o[i] = (^(data_i & SecdedParityMasks[i])) ^ SecdedInvMask[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // Error classification
  ////////////////////////////////////////////////////////////

  assign syndrome_odd = ^syndrome_o;
  assign syndrome_nz  = |syndrome_o;

  // Every column of the Hsiao matrix has odd weight, so an odd
  // syndrome is a single flip
  assign err_o[0] = syndrome_odd;

  // Nonzero even syndrome is a double flip
  assign err_o[1] = syndrome_nz & ~syndrome_odd;

endmodule

// ==== verilog/lockstep_pkg.sv ====
// Lockstep checker shared definitions
package lockstep_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  parameter int unsigned DataW = 32;
  parameter int unsigned IntgW = 7;
  parameter int unsigned CodeW = DataW + IntgW;

  ////////////////////////////////////////////////////////////
  // Load-accumulate core
  ////////////////////////////////////////////////////////////

  parameter logic [DataW-1:0] CoreBootAddr = 32'h0000_1000;
  parameter logic [DataW-1:0] CoreAddrStep = 32'd4;

  ////////////////////////////////////////////////////////////
  // Inverted Hsiao (39,32) code
  ////////////////////////////////////////////////////////////

  // Check bits are stored inverted in this pattern
  parameter logic [IntgW-1:0] SecdedInvMask = 7'h2A;

  // One mask per syndrome bit, highest syndrome bit listed first
  parameter logic [IntgW-1:0][CodeW-1:0] SecdedParityMasks = '{
    39'h4098505586,
    39'h202DCC624C,
    39'h10C2C1323B,
    39'h0831234ED1,
    39'h04413D89AA,
    39'h02DEBA8050,
    39'h012606BD25
  };

endpackage
